// File: hdl/apu_pkg.sv
`default_nettype none

package apu_pkg;

	// ####################################################################
	// Sizes and divider settings
	// ####################################################################
	localparam int NUM_CH    = 2;
	localparam int FRAME_DIV = 64; // clk cycles per length tick.
	localparam int ENV_DIV   = 4;  // Length ticks per envelope tick.
	localparam int FRAME_W   = $clog2(FRAME_DIV);
	localparam int ENV_W     = $clog2(ENV_DIV);

	localparam logic [6:0]  LEN_MAX  = 7'd64;
	localparam logic [10:0] FREQ_MAX = 11'h7ff;
	localparam logic [3:0]  VOL_MAX  = 4'hf;

	// Register indexes within a channel.
	localparam logic [1:0] REG_NRX1 = 2'd0;
	localparam logic [1:0] REG_NRX2 = 2'd1;
	localparam logic [1:0] REG_NRX3 = 2'd2;
	localparam logic [1:0] REG_NRX4 = 2'd3;

	// Handshake FSM encodings.
	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_ACCESS = 2'd1;
	localparam logic [1:0] ST_ACK    = 2'd2;

	// Duty waveforms, bit n is step n.
	localparam logic [3:0][7:0] DUTY_PAT = {
		8'b01111110,
		8'b10000111,
		8'b10000001,
		8'b00000001
	};

	// ####################################################################
	// Register layouts
	// ####################################################################
	typedef struct packed {
		logic [1:0] duty;
		logic [5:0] len_load;
	} nrx1_t;

	typedef struct packed {
		logic [3:0] init_vol;
		logic       env_inc;
		logic [2:0] env_period;
	} nrx2_t;

	typedef struct packed {
		logic [7:0] freq_lo;
	} nrx3_t;

	typedef struct packed {
		logic       trigger;
		logic       len_en;
		logic [2:0] unused;
		logic [2:0] freq_hi;
	} nrx4_t;

	// One data byte, its meaning set by the register index.
	typedef union packed {
		logic [7:0] raw;
		nrx1_t      nrx1;
		nrx2_t      nrx2;
		nrx3_t      nrx3;
		nrx4_t      nrx4;
	} reg_byte_u;

	// ####################################################################
	// Internal transfers
	// ####################################################################
	typedef struct packed {
		logic       wr;
		logic [2:0] addr; // Channel in bit 2, register in 1:0.
		reg_byte_u  data;
	} cpu_req_t;

	typedef struct packed {
		logic       valid;
		logic       ch;
		logic [1:0] idx;
		reg_byte_u  data;
	} reg_wr_t;

	typedef struct packed {
		logic       ch;
		logic [1:0] idx;
	} reg_rd_t;

	typedef struct packed {
		logic            on;
		logic [3:0]      sample;
		logic [3:0][7:0] readback; // Indexed by register.
	} chan_out_t;

endpackage

`default_nettype wire

// File: hdl/apu_bus_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module apu_bus_decoder (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              req,
	input  apu_pkg::cpu_req_t cpu_req,
	output logic              ack,
	output logic [7:0]        rdata,
	output apu_pkg::reg_wr_t  reg_wr,
	output apu_pkg::reg_rd_t  reg_rd,
	input  logic [7:0]        rd_data
);

	logic [1:0]        state;
	apu_pkg::cpu_req_t req_q;

	// ####################################################################
	// Four-phase handshake FSM
	// ####################################################################
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= apu_pkg::ST_IDLE;
			req_q <= '0;
			ack   <= 1'b0;
			rdata <= 8'h00;
		end else begin
			case (state)
				apu_pkg::ST_IDLE: begin
					ack <= 1'b0; // Falls one cycle after req low.
					if (req && !ack) begin
						req_q <= cpu_req;
						state <= apu_pkg::ST_ACCESS;
					end
				end
				apu_pkg::ST_ACCESS: begin
					rdata <= rd_data; // Readback valid during access.
					state <= apu_pkg::ST_ACK;
				end
				apu_pkg::ST_ACK: begin
					if (req) begin
						ack <= 1'b1;
					end else begin
						state <= apu_pkg::ST_IDLE;
					end
				end
				default: begin
					state <= apu_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// Single write strobe in the access cycle.
	always_comb begin
		reg_wr.valid = (state == apu_pkg::ST_ACCESS) && req_q.wr;
		reg_wr.ch    = req_q.addr[2];
		reg_wr.idx   = req_q.addr[1:0];
		reg_wr.data  = req_q.data;
	end

	always_comb begin
		reg_rd.ch  = req_q.addr[2];
		reg_rd.idx = req_q.addr[1:0];
	end

endmodule

`default_nettype wire

// File: hdl/frame_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_sequencer (
	input  logic clk,
	input  logic arst_n,
	output logic len_tick,
	output logic env_tick
);

	logic [apu_pkg::FRAME_W-1:0] div_cnt;
	logic [apu_pkg::ENV_W-1:0]   env_cnt;
	logic                        div_wrap;

	assign div_wrap = (div_cnt == apu_pkg::FRAME_W'(apu_pkg::FRAME_DIV - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt  <= '0;
			env_cnt  <= '0;
			len_tick <= 1'b0;
			env_tick <= 1'b0;
		end else begin
			div_cnt  <= div_cnt + 1'b1; // Wraps at FRAME_DIV.
			len_tick <= div_wrap;
			env_tick <= div_wrap && (env_cnt == apu_pkg::ENV_W'(apu_pkg::ENV_DIV - 1));
			if (div_wrap) begin
				env_cnt <= env_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/pulse_channel.sv
`timescale 1ns/10ps
`default_nettype none

module pulse_channel #(
	parameter int CH_INDEX = 0
) (
	input  logic                clk,
	input  logic                arst_n,
	input  apu_pkg::reg_wr_t    reg_wr,
	input  logic                len_tick,
	input  logic                env_tick,
	output apu_pkg::chan_out_t  chan_out
);

	logic [1:0]     duty_q;
	apu_pkg::nrx2_t nrx2_q;
	logic [10:0]    freq_q;
	logic           len_en_q;

	logic [6:0]  len_cnt;
	logic [3:0]  vol_q;
	logic [2:0]  env_cnt;
	logic [10:0] timer;
	logic [2:0]  step;
	logic        on_q;

	logic        wr_hit, wr_nrx1, wr_nrx2, wr_nrx3, wr_nrx4;
	logic        trigger, dac_en, len_step, duty_bit;
	logic [10:0] freq_new;

	assign wr_hit   = reg_wr.valid && (reg_wr.ch == 1'(CH_INDEX));
	assign wr_nrx1  = wr_hit && (reg_wr.idx == apu_pkg::REG_NRX1);
	assign wr_nrx2  = wr_hit && (reg_wr.idx == apu_pkg::REG_NRX2);
	assign wr_nrx3  = wr_hit && (reg_wr.idx == apu_pkg::REG_NRX3);
	assign wr_nrx4  = wr_hit && (reg_wr.idx == apu_pkg::REG_NRX4);
	assign trigger  = wr_nrx4 && reg_wr.data.nrx4.trigger;
	assign freq_new = {reg_wr.data.nrx4.freq_hi, freq_q[7:0]}; // Same-cycle high bits.
	assign dac_en   = |{nrx2_q.init_vol, nrx2_q.env_inc};
	assign len_step = len_tick && len_en_q && (len_cnt != 7'd0);

	// ####################################################################
	// Register file
	// ####################################################################
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			duty_q   <= 2'd0;
			nrx2_q   <= '0;
			freq_q   <= 11'd0;
			len_en_q <= 1'b0;
		end else begin
			if (wr_nrx1) duty_q <= reg_wr.data.nrx1.duty;
			if (wr_nrx2) nrx2_q <= reg_wr.data.nrx2;
			if (wr_nrx3) freq_q[7:0] <= reg_wr.data.nrx3.freq_lo;
			if (wr_nrx4) begin
				freq_q[10:8] <= reg_wr.data.nrx4.freq_hi;
				len_en_q     <= reg_wr.data.nrx4.len_en;
			end
		end
	end

	// ####################################################################
	// Length, envelope and channel enable
	// ####################################################################
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			len_cnt <= 7'd0;
			on_q    <= 1'b0;
		end else begin
			if (wr_nrx1) begin
				len_cnt <= apu_pkg::LEN_MAX - {1'b0, reg_wr.data.nrx1.len_load};
			end else if (trigger && (len_cnt == 7'd0)) begin
				len_cnt <= apu_pkg::LEN_MAX;
			end else if (len_step) begin
				len_cnt <= len_cnt - 1'b1;
			end

			if (!dac_en) begin
				on_q <= 1'b0;
			end else if (trigger) begin
				on_q <= 1'b1;
			end else if (len_step && (len_cnt == 7'd1)) begin
				on_q <= 1'b0; // Length expired.
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vol_q   <= 4'd0;
			env_cnt <= 3'd0;
		end else if (trigger) begin
			vol_q   <= nrx2_q.init_vol;
			env_cnt <= nrx2_q.env_period;
		end else if (env_tick && (nrx2_q.env_period != 3'd0)) begin
			if (env_cnt <= 3'd1) begin
				env_cnt <= nrx2_q.env_period;
				if (nrx2_q.env_inc && (vol_q != apu_pkg::VOL_MAX)) begin
					vol_q <= vol_q + 1'b1;
				end else if (!nrx2_q.env_inc && (vol_q != 4'd0)) begin
					vol_q <= vol_q - 1'b1;
				end
			end else begin
				env_cnt <= env_cnt - 1'b1;
			end
		end
	end

	// ####################################################################
	// Frequency timer and duty step
	// ####################################################################
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			timer <= 11'd0;
			step  <= 3'd0;
		end else if (trigger) begin
			timer <= freq_new;
			step  <= 3'd0;
		end else if (on_q) begin
			if (timer == apu_pkg::FREQ_MAX) begin
				timer <= freq_q;
				step  <= step + 1'b1;
			end else begin
				timer <= timer + 1'b1;
			end
		end
	end

	assign duty_bit = apu_pkg::DUTY_PAT[duty_q][step];

	always_comb begin
		chan_out.on     = on_q;
		chan_out.sample = (on_q && duty_bit) ? vol_q : 4'd0;
		chan_out.readback[apu_pkg::REG_NRX1] = {duty_q, 6'h3f};
		chan_out.readback[apu_pkg::REG_NRX2] = nrx2_q;
		chan_out.readback[apu_pkg::REG_NRX3] = 8'hff; // Write only.
		chan_out.readback[apu_pkg::REG_NRX4] = {1'b1, len_en_q, 6'h3f};
	end

endmodule

`default_nettype wire

// File: hdl/apu_mixer.sv
`timescale 1ns/10ps
`default_nettype none

module apu_mixer (
	input  logic                      clk,
	input  logic                      arst_n,
	input  apu_pkg::chan_out_t        chan_out [apu_pkg::NUM_CH],
	input  apu_pkg::reg_rd_t          reg_rd,
	output logic [7:0]                rd_data,
	output logic [4:0]                mix_out,
	output logic [apu_pkg::NUM_CH-1:0] chan_on
);

	logic [4:0] mix_sum;

	always_comb begin
		mix_sum = 5'd0;
		for (int i = 0; i < apu_pkg::NUM_CH; i++) begin
			mix_sum = mix_sum + 5'(chan_out[i].sample);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mix_out <= 5'd0;
		end else begin
			mix_out <= mix_sum; // One cycle of latency.
		end
	end

	always_comb begin
		for (int i = 0; i < apu_pkg::NUM_CH; i++) begin
			chan_on[i] = chan_out[i].on;
		end
	end

	// Readback select for the bus decoder.
	assign rd_data = chan_out[reg_rd.ch].readback[reg_rd.idx];

endmodule

`default_nettype wire

// File: hdl/apu_top.sv
`timescale 1ns/10ps
`default_nettype none

module apu_top (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       req,
	input  apu_pkg::cpu_req_t          cpu_req,
	output logic                       ack,
	output logic [7:0]                 rdata,
	output logic [4:0]                 mix_out,
	output logic [apu_pkg::NUM_CH-1:0] chan_on
);

	apu_pkg::reg_wr_t   reg_wr;
	apu_pkg::reg_rd_t   reg_rd;
	apu_pkg::chan_out_t chan_out [apu_pkg::NUM_CH];
	logic [7:0]         rd_data;
	logic               len_tick;
	logic               env_tick;

	apu_bus_decoder u_dec (
		.clk     (clk),
		.arst_n  (arst_n),
		.req     (req),
		.cpu_req (cpu_req),
		.ack     (ack),
		.rdata   (rdata),
		.reg_wr  (reg_wr),
		.reg_rd  (reg_rd),
		.rd_data (rd_data)
	);

	frame_sequencer u_seq (
		.clk      (clk),
		.arst_n   (arst_n),
		.len_tick (len_tick),
		.env_tick (env_tick)
	);

	// Write strobe goes to every channel, each matches its own index.
	for (genvar i = 0; i < apu_pkg::NUM_CH; i++) begin : g_ch
		pulse_channel #(.CH_INDEX(i)) u_ch (
			.clk      (clk),
			.arst_n   (arst_n),
			.reg_wr   (reg_wr),
			.len_tick (len_tick),
			.env_tick (env_tick),
			.chan_out (chan_out[i])
		);
	end

	apu_mixer u_mix (
		.clk      (clk),
		.arst_n   (arst_n),
		.chan_out (chan_out),
		.reg_rd   (reg_rd),
		.rd_data  (rd_data),
		.mix_out  (mix_out),
		.chan_on  (chan_on)
	);

endmodule

`default_nettype wire

// File: tb/apu_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module apu_assertions (
	input logic             clk,
	input logic             arst_n,
	input logic             req,
	input logic             ack,
	input apu_pkg::reg_wr_t reg_wr
);

	// ####################################################################
	// Four-phase handshake
	// ####################################################################
	ack_rise_on_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> req)
		else $error("ack rose without a pending req");

	ack_fall_after_req: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(ack) |-> !$past(req))
		else $error("ack fell while req was still high");

	// One strobe per request.
	wr_strobe_single: assert property (@(posedge clk) disable iff (!arst_n)
		reg_wr.valid |-> req ##1 !reg_wr.valid)
		else $error("reg_wr valid without req or held for more than one cycle");

endmodule

bind apu_bus_decoder apu_assertions asrt_i (
	.clk    (clk),
	.arst_n (arst_n),
	.req    (req),
	.ack    (ack),
	.reg_wr (reg_wr)
);

`default_nettype wire

// File: tb/apu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module apu_tb;

	localparam int CLK_PERIOD = 40;
	localparam int HS_TIMEOUT = 16; // Cycles allowed per handshake phase.
	localparam int HS_CYCLES  = 10; // Upper bound for one full access.
	localparam int ENV_CYCLES = apu_pkg::ENV_DIV * apu_pkg::FRAME_DIV;
	localparam int TEST_CYCLES = 10 + 16 * HS_CYCLES // Reset and readback.
		+ 2 * HS_CYCLES + 4 * (4 * HS_CYCLES + 128) // Duty.
		+ 6 * HS_CYCLES + 3 * apu_pkg::FRAME_DIV // Length.
		+ 6 * HS_CYCLES + 5 * ENV_CYCLES // Envelope.
		+ 6 * HS_CYCLES + 128 // DAC off.
		+ 10 * HS_CYCLES + 256; // Mixing.

	logic                       clk;
	logic                       arst_n;
	logic                       req;
	logic                       ack;
	apu_pkg::cpu_req_t          cpu_req;
	logic [7:0]                 rdata;
	logic [4:0]                 mix_out;
	logic [apu_pkg::NUM_CH-1:0] chan_on;
	integer                     seed;

	apu_top dut_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.req     (req),
		.cpu_req (cpu_req),
		.ack     (ack),
		.rdata   (rdata),
		.mix_out (mix_out),
		.chan_on (chan_on)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual) else
			stop_on_error($sformatf("mismatch %s expected %0d actual %0d",
				name, expected, actual));
	endtask

	// ####################################################################
	// CPU port
	// ####################################################################
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (ack !== level && n < HS_TIMEOUT);
		assert (ack === level) else
			stop_on_error($sformatf("handshake timeout, ack never went to %0b", level));
	endtask

	task automatic cpu_access(input logic wr, input logic [2:0] addr,
			input logic [7:0] wdata, output logic [7:0] rd);
		@(posedge clk);
		#2;
		cpu_req.wr       = wr;
		cpu_req.addr     = addr;
		cpu_req.data.raw = wdata;
		req              = 1'b1;
		wait_ack(1'b1);
		rd = rdata;
		@(posedge clk);
		#2;
		req = 1'b0;
		wait_ack(1'b0); // Next request only after ack is low.
	endtask

	task automatic cpu_write(input logic [2:0] addr, input logic [7:0] wdata);
		logic [7:0] ignored;
		cpu_access(1'b1, addr, wdata, ignored);
	endtask

	task automatic cpu_read(input logic [2:0] addr, output logic [7:0] rd);
		cpu_access(1'b0, addr, 8'h00, rd);
	endtask

	task automatic mute_all();
		for (int ch = 0; ch < apu_pkg::NUM_CH; ch++) begin
			cpu_write({1'(ch), apu_pkg::REG_NRX2}, 8'h00);
		end
	endtask

	// Frequency 2040, so each duty step is 8 cycles.
	task automatic start_tone(input logic ch, input logic [7:0] nrx1,
			input logic [7:0] nrx2, input logic [7:0] nrx4);
		cpu_write({ch, apu_pkg::REG_NRX2}, nrx2);
		cpu_write({ch, apu_pkg::REG_NRX1}, nrx1);
		cpu_write({ch, apu_pkg::REG_NRX3}, 8'hf8);
		cpu_write({ch, apu_pkg::REG_NRX4}, nrx4);
	endtask

	// ####################################################################
	// Tests
	// ####################################################################
	task automatic readback_rule();
		logic [7:0] wr_val [8];
		logic [7:0] exp_val;
		logic [7:0] rd;
		for (int a = 0; a < 8; a++) begin
			wr_val[a] = 8'($random(seed));
			cpu_write(3'(a), wr_val[a]);
		end
		for (int a = 0; a < 8; a++) begin
			case (a % 4)
				0: exp_val = {wr_val[a][7:6], 6'h3f};
				1: exp_val = wr_val[a];
				2: exp_val = 8'hff;
				default: exp_val = {1'b1, wr_val[a][6], 6'h3f};
			endcase
			cpu_read(3'(a), rd);
			check_value($sformatf("readback ch%0d reg%0d", a / 4, a % 4),
				int'(exp_val), int'(rd));
		end
	endtask

	task automatic duty_cycles();
		int highs [4] = '{1, 2, 4, 6};
		int count;
		mute_all();
		for (int d = 0; d < 4; d++) begin
			start_tone(1'b0, {2'(d), 6'd0}, 8'hf0, 8'h87);
			count = 0;
			repeat (128) begin
				@(negedge clk);
				if (mix_out == 5'd15) count++;
			end
			assert (count >= 16 * highs[d] - 2 && count <= 16 * highs[d] + 2) else
				stop_on_error($sformatf("mismatch duty%0d expected %0d actual %0d",
					d, 16 * highs[d], count));
		end
	endtask

	task automatic length_expiry();
		mute_all();
		start_tone(1'b0, {2'b10, 6'd62}, 8'hf0, 8'hc7);
		// First tick can land right after the trigger.
		repeat (apu_pkg::FRAME_DIV - 2) @(negedge clk);
		check_value("length still on", 1, int'(chan_on[0]));
		repeat (2 * apu_pkg::FRAME_DIV + 2) @(negedge clk);
		check_value("length expired", 0, int'(chan_on[0]));
	endtask

	task automatic envelope_ramp();
		int peak [5];
		int exp_peak;
		mute_all();
		start_tone(1'b0, 8'h80, 8'hc9, 8'h87); // Volume 12, rising, period 1.
		for (int k = 0; k < 5; k++) begin
			peak[k] = 0;
			repeat (ENV_CYCLES) begin
				@(negedge clk);
				if (int'(mix_out) > peak[k]) peak[k] = int'(mix_out);
			end
		end
		// At most two envelope ticks fall between trigger and first interval end.
		assert (peak[0] >= 12 && peak[0] <= 14) else
			stop_on_error($sformatf("mismatch envelope start expected 12 to 14 actual %0d",
				peak[0]));
		for (int k = 1; k < 5; k++) begin
			exp_peak = (peak[k - 1] < 15) ? peak[k - 1] + 1 : 15;
			check_value($sformatf("envelope interval %0d", k), exp_peak, peak[k]);
		end
		check_value("envelope hold", 15, peak[4]);
	endtask

	task automatic dac_off();
		mute_all();
		start_tone(1'b0, 8'h80, 8'h00, 8'h87);
		repeat (128) begin
			@(negedge clk);
			check_value("dac off chan_on", 0, int'(chan_on[0]));
			check_value("dac off mix_out", 0, int'(mix_out));
		end
	endtask

	task automatic two_channel_mix();
		logic seen_sum;
		mute_all();
		start_tone(1'b0, 8'hc0, 8'h70, 8'h87);
		start_tone(1'b1, 8'hc0, 8'h50, 8'h87);
		check_value("mixing chan_on", 3, int'(chan_on));
		seen_sum = 1'b0;
		repeat (256) begin
			@(negedge clk);
			assert (mix_out inside {5'd0, 5'd5, 5'd7, 5'd12}) else
				stop_on_error($sformatf("mismatch mixing expected 0, 5, 7 or 12 actual %0d",
					mix_out));
			if (mix_out == 5'd12) seen_sum = 1'b1;
		end
		assert (seen_sum) else stop_on_error("mixing never produced both channels at once");
	endtask

	initial begin
		seed    = 32'h41d5_2af9;
		clk     = 1'b0;
		arst_n  = 1'b0;
		req     = 1'b0;
		cpu_req = '0;
		repeat (10) @(posedge clk);
		#2;
		arst_n = 1'b1;
		readback_rule();
		duty_cycles();
		length_expiry();
		envelope_ramp();
		dac_off();
		two_channel_mix();
		$display(">>> PASS");
		$finish;
	end

	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		stop_on_error("watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

// File: all.f
hdl/apu_pkg.sv
hdl/apu_bus_decoder.sv
hdl/frame_sequencer.sv
hdl/pulse_channel.sv
hdl/apu_mixer.sv
hdl/apu_top.sv
tb/apu_assertions.sv
tb/apu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module apu_tb -f all.f -o apu_sim &&
./obj_dir/apu_sim || exit 1
